// File: trap_pkg.sv
package trap_pkg;

  // Machine exception codes as they appear in mcause
  typedef enum logic [4:0] {
    EXC_INSTR_FAULT     = 5'd1,
    EXC_ILLEGAL         = 5'd2,
    EXC_BREAKPOINT      = 5'd3,
    EXC_ECALL_M         = 5'd11,
    EXC_INSTR_BUS_FAULT = 5'd24
  } exc_code_t;

  // Position of the interrupt flag in mcause
  // The cause code itself sits in the low bits
  localparam int unsigned MCAUSE_IRQ_BIT = 31;

  // Bit positions in the monitor error vector
  // The first five follow the exception classes, the last one covers interrupts
  typedef enum int unsigned {
    ERR_ILLEGAL      = 0,
    ERR_ECALL        = 1,
    ERR_EBREAK       = 2,
    ERR_BUS_FAULT    = 3,
    ERR_INSTR_FAULT  = 4,
    ERR_IRQ_DISABLED = 5
  } mon_err_e;

  localparam int unsigned MON_ERR_W = 6;

  // Highest-priority cause among the flags of one instruction
  // Breakpoint is the lowest class, so it is what is left when no other flag is set
  // The caller qualifies the result with the OR of all flags
  function automatic exc_code_t exc_cause(input logic mpu_fault, input logic bus_err,
                                          input logic illegal, input logic ecall);
    exc_code_t code;
    if (mpu_fault) begin
      code = EXC_INSTR_FAULT;
    end else if (bus_err) begin
      code = EXC_INSTR_BUS_FAULT;
    end else if (illegal) begin
      code = EXC_ILLEGAL;
    end else if (ecall) begin
      code = EXC_ECALL_M;
    end else begin
      code = EXC_BREAKPOINT;
    end
    return code;
  endfunction

endpackage

// File: csr_pkg.sv
package csr_pkg;

  typedef logic [11:0] csr_addr_t;

  // Machine-mode CSRs held by the CSR file
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  // Global interrupt enable and its copy saved on trap entry
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

endpackage

// File: trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl #(
  parameter int unsigned IRQ_WIDTH = 16
) (
  input  logic                 clk,
  input  logic                 rst_ni,
  input  logic                 wb_valid_i,
  input  logic [31:0]          wb_pc_i,
  input  logic                 wb_mpu_fault_i,
  input  logic                 wb_bus_err_i,
  input  logic                 wb_illegal_i,
  input  logic                 wb_ecall_i,
  input  logic                 wb_ebreak_i,
  input  logic [IRQ_WIDTH-1:0] irq_i,
  input  logic [IRQ_WIDTH-1:0] mie_i,
  input  logic                 mstatus_mie_i,
  output logic                 wb_ready_o,
  output logic                 retire_o,
  output logic                 trap_done_o,
  output logic                 req_o,
  output csr_pkg::csr_addr_t   addr_o,
  output logic [31:0]          wdata_o,
  input  logic                 ack_i
);
  import trap_pkg::*;
  import csr_pkg::*;

  // ST_REQ holds req until ack, ST_REL waits for ack to fall again
  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_REL} state_e;

  state_e                 state_q;
  logic [1:0]             step_q;
  logic                   done_q;
  logic [31:0]            pc_q;
  logic [31:0]            cause_q;
  logic                   mie_old_q;
  logic                   wb_fire;
  logic                   exc_any;
  logic [IRQ_WIDTH-1:0]   irq_pend;
  logic                   irq_take;
  logic [4:0]             irq_idx;
  logic [31:0]            cause_d;

  ////////////////////////////////////////////////////////////////////////////
  // Trap decision at the writeback transfer
  ////////////////////////////////////////////////////////////////////////////

  assign wb_ready_o = (state_q == ST_IDLE);
  assign wb_fire    = wb_valid_i & wb_ready_o;
  assign exc_any    = wb_mpu_fault_i | wb_bus_err_i | wb_illegal_i | wb_ecall_i | wb_ebreak_i;
  assign irq_pend   = irq_i & mie_i;
  assign irq_take   = mstatus_mie_i & (|irq_pend);

  // An instruction retires only when nothing traps on it
  assign retire_o   = wb_fire & ~exc_any & ~irq_take;

  // Lowest pending and enabled line wins, so scan downwards
  always_comb begin
    irq_idx = '0;
    for (int i = IRQ_WIDTH - 1; i >= 0; i--) begin
      if (irq_pend[i]) begin
        irq_idx = 5'(i);
      end
    end
  end

  // An interrupt displaces any exception of the same instruction
  always_comb begin
    cause_d = 32'(exc_cause(wb_mpu_fault_i, wb_bus_err_i, wb_illegal_i, wb_ecall_i));
    if (irq_take) begin
      cause_d = 32'(irq_idx);
      cause_d[MCAUSE_IRQ_BIT] = 1'b1;
    end
  end

  // Values for the three saves, captured once per trap
  always_ff @(posedge clk) begin
    if (wb_fire && (exc_any || irq_take)) begin
      pc_q      <= wb_pc_i;
      cause_q   <= cause_d;
      mie_old_q <= mstatus_mie_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Save sequence over the CSR bus
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      step_q  <= 2'd0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (wb_fire && (exc_any || irq_take)) begin
            state_q <= ST_REQ;
            step_q  <= 2'd0;
          end
        end
        ST_REQ: begin
          if (ack_i) begin
            state_q <= ST_REL;
          end
        end
        ST_REL: begin
          // Step on only after the ack of the current write has dropped
          if (!ack_i) begin
            if (step_q == 2'd2) begin
              state_q <= ST_IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= ST_REQ;
              step_q  <= step_q + 2'd1;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign req_o       = (state_q == ST_REQ);
  assign trap_done_o = done_q;

  // Step 0 saves mepc, step 1 mcause, step 2 mstatus
  always_comb begin
    addr_o  = CSR_MEPC;
    wdata_o = pc_q;
    case (step_q)
      2'd1: begin
        addr_o  = CSR_MCAUSE;
        wdata_o = cause_q;
      end
      2'd2: begin
        // MIE goes to zero and its old value moves to MPIE
        addr_o                    = CSR_MSTATUS;
        wdata_o                   = '0;
        wdata_o[MSTATUS_MIE_BIT]  = 1'b0;
        wdata_o[MSTATUS_MPIE_BIT] = mie_old_q;
      end
      default: ;
    endcase
  end

endmodule

// File: csr_arbiter.sv
`timescale 1ns/1ps

module csr_arbiter (
  input  logic               clk,
  input  logic               rst_ni,
  input  logic               trap_req_i,
  input  csr_pkg::csr_addr_t trap_addr_i,
  input  logic [31:0]        trap_wdata_i,
  output logic               trap_ack_o,
  input  logic               host_req_i,
  input  csr_pkg::csr_addr_t host_addr_i,
  input  logic [31:0]        host_wdata_i,
  output logic               host_ack_o,
  output logic               bus_req_o,
  output csr_pkg::csr_addr_t bus_addr_o,
  output logic [31:0]        bus_wdata_o,
  input  logic               bus_ack_i
);

  typedef enum logic [1:0] {GNT_NONE, GNT_TRAP, GNT_HOST} gnt_e;

  gnt_e gnt_q;
  logic bus_idle;

  // A new grant waits until the previous handshake is fully closed
  assign bus_idle = ~bus_req_o & ~bus_ack_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= GNT_NONE;
    end else begin
      case (gnt_q)
        GNT_NONE: begin
          // Trap saves always go ahead of the host
          if (bus_idle && trap_req_i) begin
            gnt_q <= GNT_TRAP;
          end else if (bus_idle && host_req_i) begin
            gnt_q <= GNT_HOST;
          end
        end
        GNT_TRAP: begin
          if (!trap_req_i && !bus_ack_i) begin
            gnt_q <= GNT_NONE;
          end
        end
        GNT_HOST: begin
          if (!host_req_i && !bus_ack_i) begin
            gnt_q <= GNT_NONE;
          end
        end
        default: gnt_q <= GNT_NONE;
      endcase
    end
  end

  // Only the granted side sees the bus
  assign bus_req_o   = ((gnt_q == GNT_TRAP) & trap_req_i) | ((gnt_q == GNT_HOST) & host_req_i);
  assign bus_addr_o  = (gnt_q == GNT_HOST) ? host_addr_i : trap_addr_i;
  assign bus_wdata_o = (gnt_q == GNT_HOST) ? host_wdata_i : trap_wdata_i;
  assign trap_ack_o  = (gnt_q == GNT_TRAP) & bus_ack_i;
  assign host_ack_o  = (gnt_q == GNT_HOST) & bus_ack_i;

endmodule

// File: csr_file.sv
`timescale 1ns/1ps

module csr_file #(
  parameter int unsigned IRQ_WIDTH = 16
) (
  input  logic                 clk,
  input  logic                 rst_ni,
  input  logic                 bus_req_i,
  input  csr_pkg::csr_addr_t   bus_addr_i,
  input  logic [31:0]          bus_wdata_i,
  output logic                 bus_ack_o,
  output logic [IRQ_WIDTH-1:0] mie_o,
  output logic                 mstatus_mie_o,
  output logic [31:0]          mepc_o,
  output logic [31:0]          mcause_o
);
  import csr_pkg::*;

  // Only MIE and MPIE exist in this mstatus
  localparam logic [31:0] MSTATUS_MASK = (32'd1 << MSTATUS_MIE_BIT) |
                                         (32'd1 << MSTATUS_MPIE_BIT);

  logic                 ack_q;
  logic                 wr_en;
  logic [IRQ_WIDTH-1:0] mie_q;
  logic [31:0]          mstatus_q;
  logic [31:0]          mepc_q;
  logic [31:0]          mcause_q;

  // A request is new while its ack has not been raised yet
  assign wr_en = bus_req_i & ~ack_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q     <= 1'b0;
      mie_q     <= '0;
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      // Ack follows req with one cycle of delay on both edges
      if (wr_en) begin
        ack_q <= 1'b1;
      end else if (!bus_req_i) begin
        ack_q <= 1'b0;
      end

      // Unknown addresses are still acknowledged but change nothing
      if (wr_en) begin
        case (bus_addr_i)
          CSR_MIE:     mie_q     <= bus_wdata_i[IRQ_WIDTH-1:0];
          CSR_MSTATUS: mstatus_q <= bus_wdata_i & MSTATUS_MASK;
          CSR_MEPC:    mepc_q    <= bus_wdata_i;
          CSR_MCAUSE:  mcause_q  <= bus_wdata_i;
          default: ;
        endcase
      end
    end
  end

  assign bus_ack_o     = ack_q;
  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_q[MSTATUS_MIE_BIT];
  assign mepc_o        = mepc_q;
  assign mcause_o      = mcause_q;

endmodule

// File: trap_monitor.sv
`timescale 1ns/1ps

module trap_monitor #(
  parameter int unsigned IRQ_WIDTH = 16
) (
  input  logic                         clk,
  input  logic                         rst_ni,
  input  logic                         wb_valid_i,
  input  logic [31:0]                  wb_pc_i,
  input  logic                         wb_mpu_fault_i,
  input  logic                         wb_bus_err_i,
  input  logic                         wb_illegal_i,
  input  logic                         wb_ecall_i,
  input  logic                         wb_ebreak_i,
  input  logic                         wb_ready_i,
  input  logic [IRQ_WIDTH-1:0]         irq_i,
  input  logic [IRQ_WIDTH-1:0]         mie_i,
  input  logic                         mstatus_mie_i,
  input  logic                         bus_req_i,
  input  csr_pkg::csr_addr_t           bus_addr_i,
  input  logic [31:0]                  bus_wdata_i,
  input  logic                         bus_ack_i,
  output logic [trap_pkg::MON_ERR_W-1:0] err_o
);
  import trap_pkg::*;
  import csr_pkg::*;

  // Exception classes take the low error bits, the interrupt bit comes after them
  localparam int unsigned NUM_CLS  = int'(ERR_IRQ_DISABLED);
  localparam logic [2:0]  CLS_NONE = 3'd7;

  // Error bit of an exception code, or CLS_NONE for any other code
  function automatic logic [2:0] cls_of(input logic [4:0] code);
    logic [2:0] cls;
    case (code)
      EXC_ILLEGAL:         cls = 3'(ERR_ILLEGAL);
      EXC_ECALL_M:         cls = 3'(ERR_ECALL);
      EXC_BREAKPOINT:      cls = 3'(ERR_EBREAK);
      EXC_INSTR_BUS_FAULT: cls = 3'(ERR_BUS_FAULT);
      EXC_INSTR_FAULT:     cls = 3'(ERR_INSTR_FAULT);
      default:             cls = CLS_NONE;
    endcase
    return cls;
  endfunction

  logic                 wb_fire;
  logic                 exp_hit;
  logic [2:0]           exp_cls;
  logic                 ack_q;
  logic                 ack_rise;
  logic                 mepc_wr;
  logic                 mcause_wr;
  logic                 mc_irq;
  logic [4:0]           mc_code;
  logic [2:0]           act_cls;
  logic [31:0]          mie_ext;
  logic                 irq_ok;
  logic [NUM_CLS-1:0]   exp_new;
  logic [NUM_CLS-1:0]   act_hit;
  logic [NUM_CLS-1:0]   exp_found_q;
  logic [NUM_CLS-1:0]   act_found_q;
  logic [31:0]          exp_pc_q [NUM_CLS];
  logic [31:0]          act_pc_q [NUM_CLS];
  logic [31:0]          last_mepc_q;
  logic [MON_ERR_W-1:0] err_q;

  ////////////////////////////////////////////////////////////////////////////
  // Expected side from the writeback port
  ////////////////////////////////////////////////////////////////////////////

  assign wb_fire = wb_valid_i & wb_ready_i;
  assign exp_cls = cls_of(exc_cause(wb_mpu_fault_i, wb_bus_err_i, wb_illegal_i, wb_ecall_i));

  // An enabled interrupt takes the instruction away from its exception class
  assign exp_hit = wb_fire &
                   (wb_mpu_fault_i | wb_bus_err_i | wb_illegal_i | wb_ecall_i | wb_ebreak_i) &
                   ~(mstatus_mie_i & (|(irq_i & mie_i)));

  ////////////////////////////////////////////////////////////////////////////
  // Actual side from the CSR bus
  ////////////////////////////////////////////////////////////////////////////

  // A write counts once, on the cycle its ack rises
  assign ack_rise  = bus_req_i & bus_ack_i & ~ack_q;
  assign mepc_wr   = ack_rise & (bus_addr_i == CSR_MEPC);
  assign mcause_wr = ack_rise & (bus_addr_i == CSR_MCAUSE);
  assign mc_irq    = bus_wdata_i[MCAUSE_IRQ_BIT];
  assign mc_code   = bus_wdata_i[4:0];
  assign act_cls   = cls_of(mc_code);

  // Codes beyond the last line read as disabled
  assign mie_ext = 32'(mie_i);
  assign irq_ok  = mie_ext[mc_code] & mstatus_mie_i;

  // Only the first event of each class is kept on either side
  always_comb begin
    for (int c = 0; c < NUM_CLS; c++) begin
      exp_new[c] = exp_hit & ~exp_found_q[c] & (exp_cls == 3'(c));
      act_hit[c] = mcause_wr & ~mc_irq & ~act_found_q[c] & (act_cls == 3'(c));
    end
  end

  always_ff @(posedge clk) begin
    if (mepc_wr) begin
      last_mepc_q <= bus_wdata_i;
    end
    for (int c = 0; c < NUM_CLS; c++) begin
      if (exp_new[c]) begin
        exp_pc_q[c] <= wb_pc_i;
      end
      if (act_hit[c]) begin
        act_pc_q[c] <= last_mepc_q;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sticky error flags
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q       <= 1'b0;
      exp_found_q <= '0;
      act_found_q <= '0;
      err_q       <= '0;
    end else begin
      ack_q       <= bus_ack_i;
      exp_found_q <= exp_found_q | exp_new;
      act_found_q <= act_found_q | act_hit;
      for (int c = 0; c < NUM_CLS; c++) begin
        // Compare at the mcause ack, or later if the expected pc shows up last
        if (exp_found_q[c] &&
            ((act_hit[c] && (exp_pc_q[c] != last_mepc_q)) ||
             (act_found_q[c] && (exp_pc_q[c] != act_pc_q[c])))) begin
          err_q[c] <= 1'b1;
        end
      end
      // mstatus is saved after mcause, so MIE still shows the state at the trap
      if (mcause_wr && mc_irq && !irq_ok) begin
        err_q[ERR_IRQ_DISABLED] <= 1'b1;
      end
    end
  end

  assign err_o = err_q;

endmodule

// File: trap_top.sv
`timescale 1ns/1ps

module trap_top #(
  parameter int unsigned IRQ_WIDTH = 16
) (
  input  logic                           clk,
  input  logic                           rst_ni,
  input  logic                           wb_valid_i,
  input  logic [31:0]                    wb_pc_i,
  input  logic                           wb_mpu_fault_i,
  input  logic                           wb_bus_err_i,
  input  logic                           wb_illegal_i,
  input  logic                           wb_ecall_i,
  input  logic                           wb_ebreak_i,
  output logic                           wb_ready_o,
  input  logic [IRQ_WIDTH-1:0]           irq_i,
  input  logic                           host_req_i,
  input  csr_pkg::csr_addr_t             host_addr_i,
  input  logic [31:0]                    host_wdata_i,
  output logic                           host_ack_o,
  output logic                           retire_o,
  output logic                           trap_done_o,
  output logic [31:0]                    mepc_o,
  output logic [31:0]                    mcause_o,
  output logic [IRQ_WIDTH-1:0]           mie_o,
  output logic                           mstatus_mie_o,
  output logic [trap_pkg::MON_ERR_W-1:0] err_o
);
  import csr_pkg::*;

  // Controller side of the arbiter
  logic        trap_req;
  csr_addr_t   trap_addr;
  logic [31:0] trap_wdata;
  logic        trap_ack;

  // Shared bus into the CSR file, also watched by the monitor
  logic        bus_req;
  csr_addr_t   bus_addr;
  logic [31:0] bus_wdata;
  logic        bus_ack;

  trap_ctrl #(
    .IRQ_WIDTH(IRQ_WIDTH)
  ) trap_ctrl_inst (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .wb_valid_i    (wb_valid_i),
    .wb_pc_i       (wb_pc_i),
    .wb_mpu_fault_i(wb_mpu_fault_i),
    .wb_bus_err_i  (wb_bus_err_i),
    .wb_illegal_i  (wb_illegal_i),
    .wb_ecall_i    (wb_ecall_i),
    .wb_ebreak_i   (wb_ebreak_i),
    .irq_i         (irq_i),
    .mie_i         (mie_o),
    .mstatus_mie_i (mstatus_mie_o),
    .wb_ready_o    (wb_ready_o),
    .retire_o      (retire_o),
    .trap_done_o   (trap_done_o),
    .req_o         (trap_req),
    .addr_o        (trap_addr),
    .wdata_o       (trap_wdata),
    .ack_i         (trap_ack)
  );

  csr_arbiter csr_arbiter_inst (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .trap_req_i  (trap_req),
    .trap_addr_i (trap_addr),
    .trap_wdata_i(trap_wdata),
    .trap_ack_o  (trap_ack),
    .host_req_i  (host_req_i),
    .host_addr_i (host_addr_i),
    .host_wdata_i(host_wdata_i),
    .host_ack_o  (host_ack_o),
    .bus_req_o   (bus_req),
    .bus_addr_o  (bus_addr),
    .bus_wdata_o (bus_wdata),
    .bus_ack_i   (bus_ack)
  );

  csr_file #(
    .IRQ_WIDTH(IRQ_WIDTH)
  ) csr_file_inst (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .bus_req_i    (bus_req),
    .bus_addr_i   (bus_addr),
    .bus_wdata_i  (bus_wdata),
    .bus_ack_o    (bus_ack),
    .mie_o        (mie_o),
    .mstatus_mie_o(mstatus_mie_o),
    .mepc_o       (mepc_o),
    .mcause_o     (mcause_o)
  );

  trap_monitor #(
    .IRQ_WIDTH(IRQ_WIDTH)
  ) trap_monitor_inst (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .wb_valid_i    (wb_valid_i),
    .wb_pc_i       (wb_pc_i),
    .wb_mpu_fault_i(wb_mpu_fault_i),
    .wb_bus_err_i  (wb_bus_err_i),
    .wb_illegal_i  (wb_illegal_i),
    .wb_ecall_i    (wb_ecall_i),
    .wb_ebreak_i   (wb_ebreak_i),
    .wb_ready_i    (wb_ready_o),
    .irq_i         (irq_i),
    .mie_i         (mie_o),
    .mstatus_mie_i (mstatus_mie_o),
    .bus_req_i     (bus_req),
    .bus_addr_i    (bus_addr),
    .bus_wdata_i   (bus_wdata),
    .bus_ack_i     (bus_ack),
    .err_o         (err_o)
  );

endmodule

// File: tb_trap_top.sv
`timescale 1ns/1ps

module tb_trap_top;
  import trap_pkg::*;
  import csr_pkg::*;

  localparam int unsigned IRQ_WIDTH = 16;
  // Upper bound in clock cycles for any one handshake wait
  localparam int TIMEOUT = 200;

  logic                 clk;
  logic                 rst_ni;
  logic                 wb_valid;
  logic [31:0]          wb_pc;
  logic                 wb_mpu_fault;
  logic                 wb_bus_err;
  logic                 wb_illegal;
  logic                 wb_ecall;
  logic                 wb_ebreak;
  logic                 wb_ready;
  logic [IRQ_WIDTH-1:0] irq;
  logic                 host_req;
  csr_addr_t            host_addr;
  logic [31:0]          host_wdata;
  logic                 host_ack;
  logic                 retire;
  logic                 trap_done;
  logic [31:0]          mepc;
  logic [31:0]          mcause;
  logic [IRQ_WIDTH-1:0] mie;
  logic                 mstatus_mie;
  logic [MON_ERR_W-1:0] err;

  int                   num_checks;
  int                   num_errors;
  logic [31:0]          lcg_state;

  trap_top #(
    .IRQ_WIDTH(IRQ_WIDTH)
  ) trap_top_inst (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .wb_valid_i    (wb_valid),
    .wb_pc_i       (wb_pc),
    .wb_mpu_fault_i(wb_mpu_fault),
    .wb_bus_err_i  (wb_bus_err),
    .wb_illegal_i  (wb_illegal),
    .wb_ecall_i    (wb_ecall),
    .wb_ebreak_i   (wb_ebreak),
    .wb_ready_o    (wb_ready),
    .irq_i         (irq),
    .host_req_i    (host_req),
    .host_addr_i   (host_addr),
    .host_wdata_i  (host_wdata),
    .host_ack_o    (host_ack),
    .retire_o      (retire),
    .trap_done_o   (trap_done),
    .mepc_o        (mepc),
    .mcause_o      (mcause),
    .mie_o         (mie),
    .mstatus_mie_o (mstatus_mie),
    .err_o         (err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    num_checks++;
    if (expected !== actual) begin
      num_errors++;
      $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  // Linear congruential generator whose state is seeded in the main block
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Flags are {mpu, bus, illegal, ecall, ebreak} and the highest set flag decides
  function automatic logic [31:0] prio_cause(input logic [4:0] flags);
    logic [31:0] code;
    if (flags[4]) begin
      code = 32'(EXC_INSTR_FAULT);
    end else if (flags[3]) begin
      code = 32'(EXC_INSTR_BUS_FAULT);
    end else if (flags[2]) begin
      code = 32'(EXC_ILLEGAL);
    end else if (flags[1]) begin
      code = 32'(EXC_ECALL_M);
    end else begin
      code = 32'(EXC_BREAKPOINT);
    end
    return code;
  endfunction

  // Present one instruction and hold it until the transfer cycle
  task automatic send_instr(input logic [31:0] pc, input logic [4:0] flags,
                            output logic retired);
    int cnt;
    cnt     = 0;
    retired = 1'b0;
    @(posedge clk);
    wb_valid <= 1'b1;
    wb_pc    <= pc;
    {wb_mpu_fault, wb_bus_err, wb_illegal, wb_ecall, wb_ebreak} <= flags;
    @(negedge clk);
    while (!wb_ready && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!wb_ready) begin
      num_errors++;
      $display("ERROR: instruction at pc 0x%08h was never accepted", pc);
    end else begin
      // retire_o belongs to the transfer cycle, so sample it here
      retired = retire;
    end
    @(posedge clk);
    wb_valid <= 1'b0;
    {wb_mpu_fault, wb_bus_err, wb_illegal, wb_ecall, wb_ebreak} <= 5'b0;
  endtask

  task automatic wait_trap_done(input string name);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!trap_done && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!trap_done) begin
      num_errors++;
      $display("ERROR: %s never raised trap_done_o", name);
    end else begin
      // The writeback port reopens in the same cycle as the done pulse
      check($sformatf("%s ready at done", name), 32'd1, 32'(wb_ready));
    end
  endtask

  task automatic run_trap(input string name, input logic [31:0] pc, input logic [4:0] flags);
    logic retired;
    send_instr(pc, flags, retired);
    check($sformatf("%s retire", name), 32'd0, 32'(retired));
    @(negedge clk);
    check($sformatf("%s ready low", name), 32'd0, 32'(wb_ready));
    wait_trap_done(name);
  endtask

  // A clean instruction retires and leaves the port open
  task automatic check_retire(input string name, input logic [31:0] pc);
    logic retired;
    send_instr(pc, 5'b0, retired);
    check($sformatf("%s retire", name), 32'd1, 32'(retired));
    @(negedge clk);
    check($sformatf("%s ready", name), 32'd1, 32'(wb_ready));
    check($sformatf("%s no done", name), 32'd0, 32'(trap_done));
  endtask

  // Full four-phase write from the host side
  task automatic host_write(input csr_addr_t addr, input logic [31:0] data);
    int cnt;
    cnt = 0;
    @(posedge clk);
    host_req   <= 1'b1;
    host_addr  <= addr;
    host_wdata <= data;
    @(negedge clk);
    while (!host_ack && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!host_ack) begin
      num_errors++;
      $display("ERROR: host write to 0x%03h was never acknowledged", addr);
    end
    @(posedge clk);
    host_req <= 1'b0;
    cnt = 0;
    @(negedge clk);
    while (host_ack && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (host_ack) begin
      num_errors++;
      $display("ERROR: host ack for 0x%03h stayed high after the request dropped", addr);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    @(negedge clk);
    check("reset mepc", 32'd0, mepc);
    check("reset mcause", 32'd0, mcause);
    check("reset mie", 32'd0, 32'(mie));
    check("reset mstatus_mie", 32'd0, 32'(mstatus_mie));
    check("reset err", 32'd0, 32'(err));
    check("reset ready", 32'd1, 32'(wb_ready));
    check("reset retire", 32'd0, 32'(retire));
    check("reset trap_done", 32'd0, 32'(trap_done));
    check("reset host_ack", 32'd0, 32'(host_ack));
    check_retire("reset clean instr", 32'h0000_0100);
  endtask

  task automatic test_single_traps();
    logic [4:0]  flags;
    logic [31:0] pc;
    string       name;
    for (int i = 0; i < 5; i++) begin
      flags = 5'b1 << i;
      pc    = 32'h0000_1000 + 32'(i) * 32'h40;
      name  = $sformatf("single flags %05b", flags);
      run_trap(name, pc, flags);
      check($sformatf("%s mepc", name), pc, mepc);
      check($sformatf("%s mcause", name), prio_cause(flags), mcause);
      check($sformatf("%s mstatus_mie", name), 32'd0, 32'(mstatus_mie));
    end
  endtask

  task automatic test_priority();
    logic [31:0] r;
    logic [31:0] pc;
    logic [4:0]  flags;
    int          a;
    int          b;
    string       name;
    for (int n = 0; n < 12; n++) begin
      r = next_random();
      // Always two distinct flags plus a random extra set
      a     = int'(r[31:29]) % 5;
      b     = (a + 1 + int'(r[28:27])) % 5;
      flags = r[26:22] | (5'd1 << a) | (5'd1 << b);
      pc    = 32'h0000_2000 + 32'(n) * 32'd4;
      name  = $sformatf("priority flags %05b", flags);
      run_trap(name, pc, flags);
      check($sformatf("%s mepc", name), pc, mepc);
      check($sformatf("%s mcause", name), prio_cause(flags), mcause);
    end
  endtask

  task automatic test_interrupts();
    // Lines 2, 5 and 7 enabled
    host_write(CSR_MIE, 32'h0000_00A4);
    host_write(CSR_MSTATUS, 32'd1 << MSTATUS_MIE_BIT);
    @(negedge clk);
    check("irq mie written", 32'h0000_00A4, 32'(mie));
    check("irq mstatus_mie set", 32'd1, 32'(mstatus_mie));

    // Lines 0, 5 and 7 pending, so line 5 is the lowest enabled one
    @(posedge clk);
    irq <= 16'h00A1;
    run_trap("irq taken", 32'h0000_3000, 5'b00010);
    check("irq taken mepc", 32'h0000_3000, mepc);
    check("irq taken mcause", (32'd1 << MCAUSE_IRQ_BIT) | 32'd5, mcause);
    check("irq taken mstatus_mie", 32'd0, 32'(mstatus_mie));

    // pending line that is not enabled
    host_write(CSR_MSTATUS, 32'd1 << MSTATUS_MIE_BIT);
    @(posedge clk);
    irq <= 16'h0002;
    check_retire("irq line disabled", 32'h0000_3010);

    // Enabled lines pending but global enable off
    host_write(CSR_MSTATUS, 32'd0);
    @(posedge clk);
    irq <= 16'h0024;
    check_retire("irq global off", 32'h0000_3020);
    @(posedge clk);
    irq <= '0;
  endtask

  task automatic test_host_contention();
    logic retired;
    // Host asks while the trap already owns the bus
    send_instr(32'h0000_4000, 5'b00100, retired);
    check("contention late retire", 32'd0, 32'(retired));
    fork
      host_write(CSR_MIE, 32'h0000_0F0F);
      wait_trap_done("contention late");
    join
    @(negedge clk);
    check("contention late mie", 32'h0000_0F0F, 32'(mie));
    check("contention late mepc", 32'h0000_4000, mepc);
    check("contention late mcause", 32'(EXC_ILLEGAL), mcause);

    // Host and writeback start together and the host gets the idle bus first
    fork
      host_write(CSR_MIE, 32'h0000_00F0);
      run_trap("contention early", 32'h0000_4100, 5'b00010);
    join
    @(negedge clk);
    check("contention early mie", 32'h0000_00F0, 32'(mie));
    check("contention early mepc", 32'h0000_4100, mepc);
    check("contention early mcause", 32'(EXC_ECALL_M), mcause);
    check("contention early mstatus_mie", 32'd0, 32'(mstatus_mie));
  endtask

  task automatic test_monitor();
    @(negedge clk);
    check("monitor err", 32'd0, 32'(err));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni       = 1'b0;
    wb_valid     = 1'b0;
    wb_pc        = '0;
    wb_mpu_fault = 1'b0;
    wb_bus_err   = 1'b0;
    wb_illegal   = 1'b0;
    wb_ecall     = 1'b0;
    wb_ebreak    = 1'b0;
    irq          = '0;
    host_req     = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    num_checks   = 0;
    num_errors   = 0;
    lcg_state    = 32'd66;

    repeat (4) @(posedge clk);
    rst_ni <= 1'b1;

    test_reset();
    test_single_traps();
    test_priority();
    test_interrupts();
    test_host_contention();
    test_monitor();

    $display("Checks run: %0d, errors: %0d", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: src.f
trap_pkg.sv
csr_pkg.sv
trap_ctrl.sv
csr_arbiter.sv
csr_file.sv
trap_monitor.sv
trap_top.sv
tb_trap_top.sv

// File: Makefile
TOP := tb_trap_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module trap_top -f src.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f src.f --Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
